// File: common/cpu16_params.svh
`ifndef CPU16_PARAMS_SVH
`define CPU16_PARAMS_SVH

// data path and address width
`define CPU16_DW 16
// register address width, eight registers
`define CPU16_RAW 3
// opcode field width
`define CPU16_OPW 5
// first fetch address
`define CPU16_RESET_PC 16'h0000

`endif

// File: common/cpu16_pkg.sv
`include "cpu16_params.svh"

package cpu16_pkg;

  typedef enum logic [`CPU16_OPW-1:0] {
    OP_HALT = 5'h00,
    OP_NOP  = 5'h01, // same code the pipeline uses for a bubble
    OP_ADDI = 5'h08,
    OP_BEQZ = 5'h0c,
    OP_ST   = 5'h10,
    OP_LD   = 5'h11,
    OP_ALU  = 5'h1b  // r-type, func picks the operation
  } opcode_e;

  typedef enum logic [1:0] {
    FN_ADD = 2'b00,
    FN_SUB = 2'b01,
    FN_AND = 2'b10,
    FN_XOR = 2'b11
  } alu_func_e;

  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_MEM = 2'd1,
    RES_PC1 = 2'd2
  } result_sel_e;

  typedef struct packed {
    logic [`CPU16_DW-1:0] rs_data;
    logic [`CPU16_DW-1:0] rt_data;
    logic [`CPU16_DW-1:0] imm;
    logic [`CPU16_DW-1:0] pc;
    opcode_e opcode;
    alu_func_e func;
    result_sel_e result_sel;
    logic [`CPU16_RAW-1:0] rd;
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic branch;
    logic halt;
    logic nop;
    logic err;
  } idex_t;

endpackage

// File: common/mem_if.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu16_params.svh"

// single-beat memory request, fields held until ack
interface mem_if;
  logic req;
  logic we;
  logic [`CPU16_DW-1:0] addr;
  logic [`CPU16_DW-1:0] wdata;
  logic [`CPU16_DW-1:0] rdata; // valid in the ack cycle
  logic ack;

  modport master (
    output req, we, addr, wdata,
    input  rdata, ack
  );

  modport slave (
    input  req, we, addr, wdata,
    output rdata, ack
  );
endinterface

`default_nettype wire

// File: cpu16.f
+incdir+common
common/cpu16_pkg.sv
common/mem_if.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/id_ex.sv
hw/execute_mem.sv
hw/mem_arbiter.sv
hw/cpu16_top.sv
testbench/tb_memory.sv
testbench/cpu16_tb.sv

// File: hw/cpu16_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu16_params.svh"

module cpu16_top (
  input  logic clk,
  input  logic rst_n,
  input  logic [`CPU16_DW-1:0] mem_rdata,
  input  logic mem_ack,
  output logic mem_req,
  output logic mem_we,
  output logic [`CPU16_DW-1:0] mem_addr,
  output logic [`CPU16_DW-1:0] mem_wdata,
  output logic halted,
  output logic err
);

  mem_if fetch_bus ();
  mem_if data_bus ();
  mem_if ext_bus ();

  cpu16_pkg::idex_t idex_d;
  cpu16_pkg::idex_t idex_x;
  logic [`CPU16_DW-1:0] instr;
  logic [`CPU16_DW-1:0] instr_pc;
  logic instr_valid;
  logic stall;
  logic mem_stall;
  logic branch_taken;
  logic [`CPU16_DW-1:0] branch_target;
  logic wb_en;
  logic [`CPU16_RAW-1:0] wb_addr;
  logic [`CPU16_DW-1:0] wb_data;

  assign mem_req       = ext_bus.req;
  assign mem_we        = ext_bus.we;
  assign mem_addr      = ext_bus.addr;
  assign mem_wdata     = ext_bus.wdata;
  assign ext_bus.rdata = mem_rdata;
  assign ext_bus.ack   = mem_ack;

  fetch_unit u_fetch (
    .clk, .rst_n, .mem(fetch_bus.master), .stall, .mem_stall, .branch_taken,
    .branch_target, .halted, .instr, .instr_pc, .instr_valid
  );

  decode_stage u_decode (
    .clk, .rst_n, .instr, .instr_pc, .instr_valid, .branch_taken,
    .wb_en, .wb_addr, .wb_data, .ex_rd(idex_x.rd), .ex_reg_write(idex_x.reg_write),
    .idex(idex_d), .stall
  );

  id_ex u_id_ex (
    .clk, .rst_n, .idex_d, .stall, .mem_stall, .branch_taken, .idex_x
  );

  execute_mem u_execute (
    .clk, .rst_n, .idex(idex_x), .mem(data_bus.master), .mem_stall, .branch_taken,
    .branch_target, .wb_en, .wb_addr, .wb_data, .halted, .err
  );

  mem_arbiter u_arbiter (
    .clk, .rst_n, .inst(fetch_bus.slave), .data(data_bus.slave), .mem(ext_bus.master)
  );

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu16_params.svh"

module decode_stage (
  input  logic clk,
  input  logic rst_n,
  input  logic [`CPU16_DW-1:0] instr,
  input  logic [`CPU16_DW-1:0] instr_pc,
  input  logic instr_valid,
  input  logic branch_taken,
  input  logic wb_en,
  input  logic [`CPU16_RAW-1:0] wb_addr,
  input  logic [`CPU16_DW-1:0] wb_data,
  input  logic [`CPU16_RAW-1:0] ex_rd,
  input  logic ex_reg_write,
  output cpu16_pkg::idex_t idex,
  output logic stall
);

  logic [`CPU16_DW-1:0] rf [0:(1<<`CPU16_RAW)-1];
  cpu16_pkg::opcode_e op;
  logic [`CPU16_RAW-1:0] rs;
  logic [`CPU16_RAW-1:0] rt;
  logic uses_rs;
  logic uses_rt;

  assign op = cpu16_pkg::opcode_e'(instr[15:11]);
  assign rs = instr[10:8];
  assign rt = instr[7:5];

  always_ff @(posedge clk) begin
    if (wb_en && wb_addr != '0)
      rf[wb_addr] <= wb_data;
  end

  always_comb begin
    idex            = '0;
    idex.rs_data    = (rs == '0) ? '0 : rf[rs]; // r0 reads as zero
    idex.rt_data    = (rt == '0) ? '0 : rf[rt];
    idex.imm        = {{(`CPU16_DW-5){instr[4]}}, instr[4:0]};
    idex.pc         = instr_pc;
    idex.opcode     = op;
    idex.func       = cpu16_pkg::FN_ADD; // also forms ld/st address
    idex.result_sel = cpu16_pkg::RES_ALU;
    idex.rd         = rt;
    uses_rs         = 1'b0;
    uses_rt         = 1'b0;
    case (op)
      cpu16_pkg::OP_ALU: begin
        idex.func      = cpu16_pkg::alu_func_e'(instr[1:0]);
        idex.rd        = instr[4:2];
        idex.reg_write = 1'b1;
        uses_rs        = 1'b1;
        uses_rt        = 1'b1;
      end
      cpu16_pkg::OP_ADDI: begin
        idex.reg_write = 1'b1;
        uses_rs        = 1'b1;
      end
      cpu16_pkg::OP_LD: begin
        idex.result_sel = cpu16_pkg::RES_MEM;
        idex.reg_write  = 1'b1;
        idex.mem_read   = 1'b1;
        uses_rs         = 1'b1;
      end
      cpu16_pkg::OP_ST: begin
        idex.mem_write = 1'b1;
        uses_rs        = 1'b1;
        uses_rt        = 1'b1; // store data
      end
      cpu16_pkg::OP_BEQZ: begin
        idex.branch = 1'b1;
        uses_rs     = 1'b1;
      end
      cpu16_pkg::OP_NOP:  idex.nop  = 1'b1;
      cpu16_pkg::OP_HALT: idex.halt = 1'b1;
      default:            idex.err  = 1'b1; // unknown opcode
    endcase
    if (!instr_valid || branch_taken) begin
      idex.opcode = cpu16_pkg::OP_NOP;
      idex.rd     = '0;
      idex.reg_write = 1'b0;
      idex.mem_read  = 1'b0;
      idex.mem_write = 1'b0;
      idex.branch    = 1'b0;
      idex.halt      = 1'b0;
      idex.err       = 1'b0;
      idex.nop       = 1'b1;
    end
  end

  // RAW against the instruction in execute
  assign stall = instr_valid && ex_reg_write && ex_rd != '0 &&
                 ((uses_rs && rs == ex_rd) || (uses_rt && rt == ex_rd));

  // producer leaves execute on its writeback edge
  a_stall_release: assert property (@(posedge clk) disable iff (!rst_n)
    stall && wb_en |=> !stall)
    else $error("decode stall held after the writeback");

endmodule

`default_nettype wire

// File: hw/execute_mem.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu16_params.svh"

module execute_mem (
  input  logic clk,
  input  logic rst_n,
  input  cpu16_pkg::idex_t idex,
  mem_if.master mem,
  output logic mem_stall,
  output logic branch_taken,
  output logic [`CPU16_DW-1:0] branch_target,
  output logic wb_en,
  output logic [`CPU16_RAW-1:0] wb_addr,
  output logic [`CPU16_DW-1:0] wb_data,
  output logic halted,
  output logic err
);

  logic [`CPU16_DW-1:0] alu_b;
  logic [`CPU16_DW-1:0] alu_y;
  logic [`CPU16_DW-1:0] pc_inc;
  logic live;

  assign live   = !halted && !idex.nop; // nothing runs after halt
  assign alu_b  = (idex.opcode == cpu16_pkg::OP_ALU) ? idex.rt_data : idex.imm;
  assign pc_inc = idex.pc + 1'b1;

  always_comb begin
    case (idex.func)
      cpu16_pkg::FN_SUB: alu_y = idex.rs_data - alu_b;
      cpu16_pkg::FN_AND: alu_y = idex.rs_data & alu_b;
      cpu16_pkg::FN_XOR: alu_y = idex.rs_data ^ alu_b;
      default:           alu_y = idex.rs_data + alu_b;
    endcase
  end

  assign branch_taken  = live && idex.branch && (idex.rs_data == '0);
  assign branch_target = pc_inc + idex.imm;

  // address is rs+imm from the adder
  assign mem.req   = live && (idex.mem_read || idex.mem_write);
  assign mem.we    = idex.mem_write;
  assign mem.addr  = alu_y;
  assign mem.wdata = idex.rt_data;
  assign mem_stall = mem.req && !mem.ack;

  assign wb_en   = live && idex.reg_write && !mem_stall;
  assign wb_addr = idex.rd;

  always_comb begin
    case (idex.result_sel)
      cpu16_pkg::RES_MEM: wb_data = mem.rdata;
      cpu16_pkg::RES_PC1: wb_data = pc_inc;
      default:            wb_data = alu_y;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      halted <= 1'b0;
      err    <= 1'b0;
    end else begin
      if (live && idex.halt)
        halted <= 1'b1; // sticky
      if (live && idex.err)
        err <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu16_params.svh"

module fetch_unit (
  input  logic clk,
  input  logic rst_n,
  mem_if.master mem,
  input  logic stall,
  input  logic mem_stall,
  input  logic branch_taken,
  input  logic [`CPU16_DW-1:0] branch_target,
  input  logic halted,
  output logic [`CPU16_DW-1:0] instr,
  output logic [`CPU16_DW-1:0] instr_pc,
  output logic instr_valid
);

  logic [`CPU16_DW-1:0] pc;
  logic [`CPU16_DW-1:0] fetch_addr; // address of the read in flight
  logic req_q;
  logic drop;                       // in-flight read belongs to a flushed path
  logic advance;
  logic start;
  logic accept;

  assign advance = !stall && !mem_stall; // decode takes the register
  assign start   = !req_q && !halted && !branch_taken && (!instr_valid || advance);
  assign accept  = req_q && mem.ack && !drop && !branch_taken;

  assign mem.req   = req_q;
  assign mem.we    = 1'b0;
  assign mem.addr  = fetch_addr;
  assign mem.wdata = '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc          <= `CPU16_RESET_PC;
      req_q       <= 1'b0;
      drop        <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      if (start)
        req_q <= 1'b1;
      else if (mem.ack)
        req_q <= 1'b0;

      if (branch_taken && req_q && !mem.ack)
        drop <= 1'b1;
      else if (mem.ack)
        drop <= 1'b0;

      if (branch_taken)
        pc <= branch_target;
      else if (accept)
        pc <= fetch_addr + 1'b1;

      if (branch_taken)
        instr_valid <= 1'b0; // flush
      else if (accept)
        instr_valid <= 1'b1;
      else if (advance)
        instr_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start)
      fetch_addr <= pc;
    if (accept) begin
      instr    <= mem.rdata;
      instr_pc <= fetch_addr;
    end
  end

endmodule

`default_nettype wire

// File: hw/id_ex.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu16_params.svh"

module id_ex (
  input  logic clk,
  input  logic rst_n,
  input  cpu16_pkg::idex_t idex_d,
  input  logic stall,
  input  logic mem_stall,
  input  logic branch_taken,
  output cpu16_pkg::idex_t idex_x
);

  cpu16_pkg::idex_t bubble;

  // payload kept, control cleared
  always_comb begin
    bubble           = idex_x;
    bubble.opcode    = cpu16_pkg::OP_NOP;
    bubble.rd        = '0;
    bubble.reg_write = 1'b0;
    bubble.mem_read  = 1'b0;
    bubble.mem_write = 1'b0;
    bubble.branch    = 1'b0;
    bubble.halt      = 1'b0;
    bubble.nop       = 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idex_x        <= '0;
      idex_x.opcode <= cpu16_pkg::OP_NOP;
      idex_x.nop    <= 1'b1;
    end else if (!mem_stall) begin // frozen while memory busy
      if (stall) begin
        idex_x <= bubble; // err rides along from idex_x
      end else begin
        idex_x <= idex_d;
        if (branch_taken)
          idex_x.halt <= 1'b0; // halt in branch shadow
      end
    end
  end

  a_bubble_no_write: assert property (@(posedge clk) disable iff (!rst_n)
    idex_x.nop |-> !idex_x.reg_write && !idex_x.mem_read && !idex_x.mem_write)
    else $error("bubble carries a write");

endmodule

`default_nettype wire

// File: hw/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu16_params.svh"

module mem_arbiter (
  input  logic clk,
  input  logic rst_n,
  mem_if.slave inst,
  mem_if.slave data,
  mem_if.master mem
);

  typedef enum logic {ST_IDLE, ST_BUSY} state_e;

  state_e state;
  logic owner_data;
  logic sel_data;

  // data side wins a tie in idle
  assign sel_data = (state == ST_BUSY) ? owner_data : data.req;

  assign mem.req   = sel_data ? data.req   : inst.req;
  assign mem.we    = sel_data ? data.we    : inst.we;
  assign mem.addr  = sel_data ? data.addr  : inst.addr;
  assign mem.wdata = sel_data ? data.wdata : inst.wdata;

  assign inst.rdata = mem.rdata;
  assign data.rdata = mem.rdata;
  assign inst.ack   = mem.ack && !sel_data;
  assign data.ack   = mem.ack && sel_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      owner_data <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (mem.req && !mem.ack) begin
            state      <= ST_BUSY;
            owner_data <= sel_data;
          end
        end
        default: begin
          if (mem.ack)
            state <= ST_IDLE;
        end
      endcase
    end
  end

  a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
    mem.ack |-> (inst.ack && inst.req) != (data.ack && data.req))
    else $error("ack not routed to exactly one requesting master");

  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem.req && !mem.ack |=>
      mem.req && $stable(mem.addr) && $stable(mem.we) && $stable(mem.wdata))
    else $error("memory request changed before ack");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpu16_tb \
  -f cpu16.f -o cpu16_sim

./obj_dir/cpu16_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Everything OK$" sim.log; then
  exit 0
else
  exit 1
fi

// File: testbench/cpu16_tb.sv
`timescale 1ns/10ps
`include "cpu16_params.svh"

module cpu16_tb;

  localparam int N_STORES     = 5;
  localparam int CYCLE_LIMIT  = 40 * 12;
  localparam int QUIET_CYCLES = 20;
  localparam int T_RESET = 0;
  localparam int T_ALU   = 1;
  localparam int T_LDST  = 2;
  localparam int T_BR    = 3;
  localparam int T_HALT  = 4;

  logic clk;
  logic rst_n;
  logic [`CPU16_DW-1:0] mem_rdata;
  logic mem_ack;
  logic mem_req;
  logic mem_we;
  logic [`CPU16_DW-1:0] mem_addr;
  logic [`CPU16_DW-1:0] mem_wdata;
  logic halted;
  logic err;

  logic [15:0] exp_addr [0:N_STORES-1];
  logic [15:0] exp_data [0:N_STORES-1];
  int exp_test [0:N_STORES-1];
  logic [15:0] r [0:7];
  logic [15:0] skip_addr;
  logic [15:0] exp_addr_now;
  logic [15:0] exp_data_now;
  int test_now;
  int store_cnt;
  int fail_cnt [0:4];
  string test_name [0:4];
  logic quiet_armed;
  logic store_fire;
  int cycle_cnt;
  int total;
  int failed_tests;

  tb_memory u_memory (
    .clk, .rst_n, .req(mem_req), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata),
    .rdata(mem_rdata), .ack(mem_ack)
  );

  cpu16_top uut (
    .clk, .rst_n, .mem_rdata, .mem_ack, .mem_req, .mem_we, .mem_addr, .mem_wdata,
    .halted, .err
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  assign store_fire = mem_req && mem_we && mem_ack;

  always_comb begin
    exp_addr_now = 16'hdead; // past the last expected store
    exp_data_now = 16'hdead;
    test_now     = T_BR;
    if (store_cnt < N_STORES) begin
      exp_addr_now = exp_addr[store_cnt];
      exp_data_now = exp_data[store_cnt];
      test_now     = exp_test[store_cnt];
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      store_cnt <= 0;
    else if (store_fire)
      store_cnt <= store_cnt + 1;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  a_store_value: assert property (@(posedge clk) disable iff (!rst_n)
    store_fire |-> store_cnt < N_STORES && mem_addr == exp_addr_now &&
                   mem_wdata == exp_data_now)
    else begin
      $display("CHECK FAILED %s: expected [%h]=%h, actual [%h]=%h",
               test_name[$sampled(test_now)], $sampled(exp_addr_now),
               $sampled(exp_data_now), $sampled(mem_addr), $sampled(mem_wdata));
      fail_cnt[$sampled(test_now)]++;
    end

  a_skipped_store: assert property (@(posedge clk) disable iff (!rst_n)
    store_fire |-> mem_addr != skip_addr)
    else begin
      $display("store in the branch shadow reached memory");
      fail_cnt[T_BR]++;
    end

  a_halt_order: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(halted) |-> store_cnt == N_STORES)
    else begin
      $display("core halted before all stores were done");
      fail_cnt[T_BR]++;
    end

  a_err_low: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(err) |-> 1'b0)
    else begin
      $display("err was raised during the program");
      fail_cnt[T_HALT]++;
    end

  a_quiet_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
    quiet_armed |-> !mem_req && halted)
    else begin
      $display("memory request or halt drop after the core halted");
      fail_cnt[T_HALT]++;
    end

  // expected stores from a register model of the program
  task automatic build_expected();
    r[1] = 16'd9;
    r[2] = r[1] - 16'd3;
    r[3] = r[1] + r[2];
    r[4] = r[1] - r[3];
    r[5] = r[4] & r[3];
    r[6] = r[5] ^ r[4];
    r[7] = r[3] + r[3];
    r[7] = r[7] + r[7];
    exp_addr[0] = r[7];
    exp_data[0] = r[6];
    exp_test[0] = T_ALU;
    exp_addr[1] = r[7] + 16'd1;
    exp_data[1] = r[5];
    exp_test[1] = T_ALU;
    r[1] = 16'h1234;
    r[2] = r[1] + 16'd13;
    exp_addr[2] = r[7] + 16'd5;
    exp_data[2] = r[2];
    exp_test[2] = T_LDST;
    r[3] = r[2];
    r[4] = r[3] - r[1];
    exp_addr[3] = r[7] + 16'd6;
    exp_data[3] = r[4];
    exp_test[3] = T_LDST;
    skip_addr   = r[7] + 16'd7;
    exp_addr[4] = r[7] + 16'd8;
    exp_data[4] = r[3];
    exp_test[4] = T_BR;
  endtask

  task automatic report_test(input int t);
    $display("test %-10s %s, %0d errors", test_name[t],
             (fail_cnt[t] == 0) ? "passed" : "FAILED", fail_cnt[t]);
  endtask

  initial begin
    rst_n       = 1'b0;
    quiet_armed = 1'b0;
    cycle_cnt   = 0;
    for (int i = 0; i < 5; i++)
      fail_cnt[i] = 0;
    test_name[0] = "reset";
    test_name[1] = "alu_chain";
    test_name[2] = "load_store";
    test_name[3] = "branch";
    test_name[4] = "halt";
    build_expected();
    repeat (2) @(posedge clk);
    @(negedge clk);
    assert (!mem_req && !halted && !err)
      else begin
        $display("CHECK FAILED %s: expected req/halted/err 000, actual %b%b%b",
                 test_name[T_RESET], mem_req, halted, err);
        fail_cnt[T_RESET]++;
      end
    rst_n = 1'b1;
    report_test(T_RESET);
    while (store_cnt < 2) @(posedge clk);
    @(negedge clk);
    report_test(T_ALU);
    while (store_cnt < 4) @(posedge clk);
    @(negedge clk);
    report_test(T_LDST);
    while (!halted) @(posedge clk);
    @(negedge clk);
    report_test(T_BR);
    while (mem_req) @(negedge clk); // a fetch may still be in flight
    quiet_armed = 1'b1;
    repeat (QUIET_CYCLES) @(posedge clk);
    @(negedge clk);
    report_test(T_HALT);
    total = 0;
    failed_tests = 0;
    for (int i = 0; i < 5; i++) begin
      total += fail_cnt[i];
      if (fail_cnt[i] != 0)
        failed_tests++;
    end
    $display("tests 5, failed %0d, errors %0d", failed_tests, total);
    if (total == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: testbench/tb_memory.sv
`timescale 1ns/10ps
`include "cpu16_params.svh"

module tb_memory (
  input  logic clk,
  input  logic rst_n,
  input  logic req,
  input  logic we,
  input  logic [`CPU16_DW-1:0] addr,
  input  logic [`CPU16_DW-1:0] wdata,
  output logic [`CPU16_DW-1:0] rdata,
  output logic ack
);

  logic [`CPU16_DW-1:0] mem [0:255];
  logic [1:0] wait_cnt;
  integer seed;
  integer i;

  function automatic logic [15:0] i_type(input logic [4:0] op, input logic [2:0] rs,
                                         input logic [2:0] rt, input logic [4:0] imm);
    i_type = {op, rs, rt, imm};
  endfunction

  function automatic logic [15:0] r_type(input logic [2:0] rs, input logic [2:0] rt,
                                         input logic [2:0] rd, input logic [1:0] fn);
    r_type = {cpu16_pkg::OP_ALU, rs, rt, rd, fn};
  endfunction

  initial begin
    seed = 86008;
    for (i = 0; i < 256; i = i + 1)
      mem[i] = i[15:0] ^ 16'hc3c3; // fill, every word differs
    mem[0]  = i_type(cpu16_pkg::OP_ADDI, 3'd0, 3'd1, 5'd9);
    mem[1]  = i_type(cpu16_pkg::OP_ADDI, 3'd1, 3'd2, 5'h1d);   // -3
    mem[2]  = r_type(3'd1, 3'd2, 3'd3, cpu16_pkg::FN_ADD);
    mem[3]  = r_type(3'd1, 3'd3, 3'd4, cpu16_pkg::FN_SUB);
    mem[4]  = r_type(3'd4, 3'd3, 3'd5, cpu16_pkg::FN_AND);
    mem[5]  = r_type(3'd5, 3'd4, 3'd6, cpu16_pkg::FN_XOR);
    mem[6]  = r_type(3'd3, 3'd3, 3'd7, cpu16_pkg::FN_ADD);
    mem[7]  = r_type(3'd7, 3'd7, 3'd7, cpu16_pkg::FN_ADD);
    mem[8]  = i_type(cpu16_pkg::OP_ST,   3'd7, 3'd6, 5'd0);
    mem[9]  = i_type(cpu16_pkg::OP_ST,   3'd7, 3'd5, 5'd1);
    mem[10] = i_type(cpu16_pkg::OP_LD,   3'd7, 3'd1, 5'd4);
    mem[11] = i_type(cpu16_pkg::OP_ADDI, 3'd1, 3'd2, 5'd13);
    mem[12] = i_type(cpu16_pkg::OP_ST,   3'd7, 3'd2, 5'd5);
    mem[13] = i_type(cpu16_pkg::OP_LD,   3'd7, 3'd3, 5'd5);
    mem[14] = r_type(3'd3, 3'd1, 3'd4, cpu16_pkg::FN_SUB);
    mem[15] = i_type(cpu16_pkg::OP_ST,   3'd7, 3'd4, 5'd6);
    mem[16] = i_type(cpu16_pkg::OP_BEQZ, 3'd0, 3'd0, 5'd2);   // taken
    mem[17] = i_type(cpu16_pkg::OP_ST,   3'd7, 3'd1, 5'd7);   // shadow
    mem[18] = i_type(cpu16_pkg::OP_HALT, 3'd0, 3'd0, 5'd0);   // shadow
    mem[19] = i_type(cpu16_pkg::OP_BEQZ, 3'd5, 3'd0, 5'd3);   // falls through
    mem[20] = i_type(cpu16_pkg::OP_ST,   3'd7, 3'd3, 5'd8);
    mem[21] = i_type(cpu16_pkg::OP_HALT, 3'd0, 3'd0, 5'd0);
    mem[8'h40] = 16'h1234; // load source
  end

  assign rdata = mem[addr[7:0]];

  // ack decided on the falling edge, 0 to 3 wait cycles
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack      <= 1'b0;
      wait_cnt <= 2'd0;
    end else if (ack) begin
      ack      <= 1'b0;
      wait_cnt <= 2'({$random(seed)} % 4);
    end else if (req) begin
      if (wait_cnt == 2'd0)
        ack <= 1'b1;
      else
        wait_cnt <= wait_cnt - 2'd1;
    end
  end

  always @(posedge clk) begin
    if (req && we && ack) begin
      mem[addr[7:0]] <= wdata;
      $display("store [%h] <= %h", addr, wdata);
    end
  end

endmodule
